// File: verif/dma_trace.txt
# op addr len size first err: op 1 writes and 0 reads, all fields hex
# beat k carries first plus k, err is the expected error flag after the burst
1 00000000 07 2 10000000 0
0 00000000 07 2 10000000 0
1 00000100 00 2 cafe0000 0
0 00000100 00 2 cafe0000 0
1 00000040 03 2 20000000 0
1 00000200 0f 2 30000000 0
0 00000040 03 2 20000000 0
0 00000000 07 2 10000000 0
1 00000800 03 2 dead0000 1
1 00000080 01 2 40000000 0
1 00000900 00 2 beef0000 1
0 00000080 01 2 40000000 0
0 00000a00 02 2 00000000 1
0 00000200 0f 2 30000000 0
1 00000040 03 2 21000000 0
0 00000040 03 2 21000000 0
1 000000c0 00 2 50000000 0
0 00000100 00 2 cafe0000 0
0 000000c0 00 2 50000000 0
1 00000300 07 2 60000000 0
0 00000800 00 2 00000000 1
0 00000300 07 2 60000000 0
1 00000000 00 2 70000000 0
0 00000000 00 2 70000000 0
0 00000004 06 2 10000001 0
1 000003f0 03 2 80000000 0
0 000003f0 03 2 80000000 0
0 00000200 0f 2 30000000 0

// File: sources.f
common/axi_dma_pkg.sv
axi_dma/axi_dma_w.sv
axi_dma/axi_dma_r.sv
axi_dma/axi_dma_steer.sv
design/dma_subsys_top.sv
verif/axi_slave_mem.sv
verif/axi_dma_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=axi_dma_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" \
	-f sources.f -o sim_bin
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_bin > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$log"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: verif/axi_dma_tb.sv
`timescale 1ns/10ps

module axi_dma_tb;

	typedef struct packed {
		logic                  op;
		axi_dma_pkg::addr_t    addr;
		axi_dma_pkg::len_t     len;
		axi_dma_pkg::size_t    size;
		axi_dma_pkg::data_t    first;
		logic                  err;
	} trace_t;

	logic                   clk;
	logic                   rst;
	logic                   valid;
	axi_dma_pkg::addr_t     addr;
	axi_dma_pkg::data_t     wdata;
	axi_dma_pkg::strb_t     wstrb;
	axi_dma_pkg::dma_cfg_t  cfg;
	logic                   ready;
	axi_dma_pkg::data_t     rdata;
	logic                   error;
	axi_dma_pkg::axi_addr_t aw;
	axi_dma_pkg::axi_addr_t ar;
	axi_dma_pkg::axi_w_t    w;
	axi_dma_pkg::axi_r_t    r;
	axi_dma_pkg::resp_t     bresp;
	logic                   awvalid;
	logic                   awready;
	logic                   wvalid;
	logic                   wready;
	logic                   bvalid;
	logic                   bready;
	logic                   arvalid;
	logic                   arready;
	logic                   rvalid;
	logic                   rready;

	trace_t                 trace_q [$];
	axi_dma_pkg::data_t     model [axi_dma_pkg::addr_t];
	int                     checks;
	int                     mismatches;
	int                     other_errs;
	int                     cycles;
	int                     limit;

	dma_subsys_top uut (
		.clk(clk), .rst(rst), .valid(valid), .addr(addr), .wdata(wdata),
		.wstrb(wstrb), .cfg(cfg), .ready(ready), .rdata(rdata), .error(error),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	axi_slave_mem u_mem (
		.clk(clk), .rst(rst),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic load_trace();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_op, f_addr, f_len, f_size, f_first, f_err;
		trace_t      t;
		fd = $fopen("verif/dma_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file verif/dma_trace.txt");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h",
					f_op, f_addr, f_len, f_size, f_first, f_err);
				if (n == 6) begin
					t = '{op: f_op[0], addr: f_addr, len: f_len[7:0], size: f_size[2:0],
						first: f_first, err: f_err[0]};
					trace_q.push_back(t);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_read(input axi_dma_pkg::addr_t a, input axi_dma_pkg::data_t exp_val);
		checks++;
		if (model.exists(a) && model[a] != exp_val) begin
			other_errs++;
			$display("Trace expects %h at %h but the last write there was %h",
				exp_val, a, model[a]);
		end
		if (rdata !== exp_val) begin
			mismatches++;
			$display("MISMATCH at %0t: read %h at %h, expected %h", $time, rdata, a, exp_val);
		end
	endtask

	// Address phase carries the request with INCR bursts, cache 2 and prot 2
	task automatic check_addr_phase(input axi_dma_pkg::axi_addr_t a, input trace_t t);
		checks++;
		if (a.addr !== t.addr || a.len !== t.len || a.size !== t.size ||
			a.burst !== 2'b01 || a.cache !== 4'h2 || a.prot !== 3'h2) begin
			mismatches++;
			$display("MISMATCH at %0t: address phase %h/%h/%h/%h/%h/%h for burst at %h",
				$time, a.addr, a.len, a.size, a.burst, a.cache, a.prot, t.addr);
		end
	endtask

	// One databus burst, then the error flag one cycle after completion
	task automatic run_burst(input trace_t t);
		int                 beat;
		axi_dma_pkg::addr_t beat_addr;
		axi_dma_pkg::data_t beat_data;
		logic               last_seen;
		beat = 0;
		@(posedge clk);
		valid <= 1'b1;
		addr  <= t.addr;
		wdata <= t.first;
		wstrb <= {axi_dma_pkg::STRB_W{t.op}};
		cfg   <= '{len: t.len, size: t.size};
		while (beat <= int'(t.len)) begin
			@(negedge clk);
			if (t.op && awvalid && awready)
				check_addr_phase(aw, t);
			if (!t.op && arvalid && arready)
				check_addr_phase(ar, t);
			if (ready) begin
				beat_addr = t.addr + (axi_dma_pkg::addr_t'(beat) << t.size);
				beat_data = t.first + axi_dma_pkg::data_t'(beat);
				last_seen = t.op ? w.last : r.last;
				checks++;
				if (last_seen != (beat == int'(t.len))) begin
					mismatches++;
					$display("MISMATCH at %0t: last %0b on beat %0d of burst at %h",
						$time, last_seen, beat, t.addr);
				end
				if (t.op && w.strb !== {axi_dma_pkg::STRB_W{1'b1}}) begin
					mismatches++;
					$display("MISMATCH at %0t: strobe %h on beat %0d of burst at %h",
						$time, w.strb, beat, t.addr);
				end
				if (!t.op && !t.err)
					check_read(beat_addr, beat_data);
				if (t.op && !t.err)
					model[beat_addr] = beat_data;
				beat++;
				@(posedge clk);
				wdata <= t.first + axi_dma_pkg::data_t'(beat);
				if (beat > int'(t.len))
					valid <= 1'b0;
			end
		end
		if (t.op) begin
			@(negedge clk);
			while (!(bvalid && bready)) begin
				if (ready) begin
					other_errs++;
					$display("Extra ready pulse after the write burst at %h", t.addr);
				end
				@(negedge clk);
			end
		end
		@(negedge clk);
		checks++;
		if (ready) begin
			other_errs++;
			$display("Extra ready pulse after the burst at %h", t.addr);
		end
		if (error !== t.err) begin
			mismatches++;
			$display("MISMATCH at %0t: error %0b after burst at %h, expected %0b",
				$time, error, t.addr, t.err);
		end
	endtask

	// Cycle limit armed once the trace length is known
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		other_errs++;
		$display("Run timed out after %0d cycles", limit);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, other_errs);
		$display("Errors found");
		$finish;
	end

	initial begin
		int max_len;
		valid      = 1'b0;
		addr       = '0;
		wdata      = '0;
		wstrb      = '0;
		cfg        = '0;
		rst        = 1'b1;
		checks     = 0;
		mismatches = 0;
		other_errs = 0;
		limit      = 0;
		max_len    = 0;
		load_trace();
		if (trace_q.size() == 0) begin
			other_errs++;
			$display("The trace holds no bursts");
		end else begin
			foreach (trace_q[i])
				if (int'(trace_q[i].len) > max_len)
					max_len = int'(trace_q[i].len);
			limit = trace_q.size() * (max_len + 1) * 8 + 200;
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checks++;
		if (ready || error) begin
			mismatches++;
			$display("MISMATCH at %0t: ready %0b error %0b after reset, expected both low",
				$time, ready, error);
		end
		foreach (trace_q[i])
			run_burst(trace_q[i]);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: verif/axi_slave_mem.sv
`timescale 1ns/10ps

module axi_slave_mem (
	input  logic                   clk,
	input  logic                   rst,

	// Write side
	input  axi_dma_pkg::axi_addr_t aw,
	input  logic                   awvalid,
	output logic                   awready,
	input  axi_dma_pkg::axi_w_t    w,
	input  logic                   wvalid,
	output logic                   wready,
	output axi_dma_pkg::resp_t     bresp,
	output logic                   bvalid,
	input  logic                   bready,

	// Read side
	input  axi_dma_pkg::axi_addr_t ar,
	input  logic                   arvalid,
	output logic                   arready,
	output axi_dma_pkg::axi_r_t    r,
	output logic                   rvalid,
	input  logic                   rready
);

	localparam axi_dma_pkg::addr_t ERR_BASE    = 32'h0000_0800;
	localparam axi_dma_pkg::resp_t RESP_SLVERR = 2'b10;

	axi_dma_pkg::data_t mem [0:255];
	integer             seed = 32'h2507d068;

	logic               w_go;
	logic               ar_go;
	logic               r_go;
	logic               wr_act;
	logic               wr_err;
	axi_dma_pkg::addr_t wr_addr;
	axi_dma_pkg::size_t wr_size;
	logic               rd_act;
	axi_dma_pkg::addr_t rd_addr;
	axi_dma_pkg::size_t rd_size;
	axi_dma_pkg::len_t  rd_len;
	axi_dma_pkg::len_t  rd_cnt;

	// Fill with a pattern built from the byte address
	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hface_0000 + i * 4;
	end

	// One burst at a time per direction
	assign awready = !wr_act && !bvalid;
	assign wready  = wr_act && w_go;
	assign arready = !rd_act && ar_go;

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			w_go    <= 1'b0;
			ar_go   <= 1'b0;
			r_go    <= 1'b0;
			wr_act  <= 1'b0;
			wr_err  <= 1'b0;
			wr_addr <= '0;
			wr_size <= '0;
			bvalid  <= 1'b0;
			bresp   <= '0;
			rd_act  <= 1'b0;
			rd_addr <= '0;
			rd_size <= '0;
			rd_len  <= '0;
			rd_cnt  <= '0;
			rvalid  <= 1'b0;
			r       <= '0;
		end else begin
			// Roughly one stall cycle in four on each channel
			w_go  <= ($random(seed) & 3) != 0;
			ar_go <= ($random(seed) & 3) != 0;
			r_go  <= ($random(seed) & 3) != 0;

			if (awvalid && awready) begin
				wr_act  <= 1'b1;
				wr_err  <= 1'b0;
				wr_addr <= aw.addr;
				wr_size <= aw.size;
			end
			if (wvalid && wready) begin
				if (wr_addr >= ERR_BASE)
					wr_err <= 1'b1;
				else
					mem[wr_addr[9:2]] <= w.data;
				wr_addr <= wr_addr + (32'd1 << wr_size);
				if (w.last) begin
					wr_act <= 1'b0;
					bvalid <= 1'b1;
					if (wr_err || wr_addr >= ERR_BASE)
						bresp <= RESP_SLVERR;
					else
						bresp <= axi_dma_pkg::RESP_OKAY;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0;

			if (arvalid && arready) begin
				rd_act  <= 1'b1;
				rd_addr <= ar.addr;
				rd_size <= ar.size;
				rd_len  <= ar.len;
				rd_cnt  <= '0;
			end
			if (rvalid && rready) begin
				rvalid  <= 1'b0;
				rd_addr <= rd_addr + (32'd1 << rd_size);
				rd_cnt  <= rd_cnt + 8'd1;
				if (r.last)
					rd_act <= 1'b0;
			end else if (rd_act && !rvalid && r_go) begin
				rvalid <= 1'b1;
				r.last <= (rd_cnt == rd_len);
				if (rd_addr >= ERR_BASE) begin
					r.data <= '0;
					r.resp <= RESP_SLVERR;
				end else begin
					r.data <= mem[rd_addr[9:2]];
					r.resp <= axi_dma_pkg::RESP_OKAY;
				end
			end
		end
	end

endmodule

// File: design/dma_subsys_top.sv
`timescale 1ns/10ps

module dma_subsys_top (
	input  logic                   clk,
	input  logic                   rst,

	// Databus
	input  logic                   valid,
	input  axi_dma_pkg::addr_t     addr,
	input  axi_dma_pkg::data_t     wdata,
	input  axi_dma_pkg::strb_t     wstrb,
	input  axi_dma_pkg::dma_cfg_t  cfg,
	output logic                   ready,
	output axi_dma_pkg::data_t     rdata,
	output logic                   error,

	// AXI master port
	output axi_dma_pkg::axi_addr_t aw,
	output logic                   awvalid,
	input  logic                   awready,
	output axi_dma_pkg::axi_w_t    w,
	output logic                   wvalid,
	input  logic                   wready,
	input  axi_dma_pkg::resp_t     bresp,
	input  logic                   bvalid,
	output logic                   bready,
	output axi_dma_pkg::axi_addr_t ar,
	output logic                   arvalid,
	input  logic                   arready,
	input  axi_dma_pkg::axi_r_t    r,
	input  logic                   rvalid,
	output logic                   rready
);

	logic                     wr_valid;
	logic                     rd_valid;
	logic                     wr_ready;
	logic                     rd_ready;
	axi_dma_pkg::data_t       rd_data;
	axi_dma_pkg::eng_status_t wr_status;
	axi_dma_pkg::eng_status_t rd_status;

	axi_dma_steer u_steer (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.wstrb     (wstrb),
		.wr_ready  (wr_ready),
		.rd_ready  (rd_ready),
		.rd_data   (rd_data),
		.wr_status (wr_status),
		.rd_status (rd_status),
		.wr_valid  (wr_valid),
		.rd_valid  (rd_valid),
		.ready     (ready),
		.rdata     (rdata),
		.error     (error)
	);

	axi_dma_w u_dma_w (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (wr_valid),
		.req_addr   (addr),
		.req_wdata  (wdata),
		.req_wstrb  (wstrb),
		.cfg        (cfg),
		.beat_ready (wr_ready),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.status     (wr_status)
	);

	axi_dma_r u_dma_r (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (rd_valid),
		.req_addr   (addr),
		.cfg        (cfg),
		.beat_ready (rd_ready),
		.rdata      (rd_data),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.status     (rd_status)
	);

endmodule

// File: axi_dma/axi_dma_steer.sv
`timescale 1ns/10ps

module axi_dma_steer (
	input  logic                     clk,
	input  logic                     rst,

	// Databus request
	input  logic                     valid,
	input  axi_dma_pkg::strb_t       wstrb,

	// Engine replies
	input  logic                     wr_ready,
	input  logic                     rd_ready,
	input  axi_dma_pkg::data_t       rd_data,
	input  axi_dma_pkg::eng_status_t wr_status,
	input  axi_dma_pkg::eng_status_t rd_status,

	// Engine requests
	output logic                     wr_valid,
	output logic                     rd_valid,

	// Databus reply
	output logic                     ready,
	output axi_dma_pkg::data_t       rdata,
	output logic                     error
);

	logic busy;
	logic sel_wr;
	logic pick_wr;

	// Latched choice while a burst is open, strobe decides otherwise
	assign pick_wr  = busy ? sel_wr : (wstrb != '0);
	assign wr_valid = valid && pick_wr;
	assign rd_valid = valid && !pick_wr;

	// Only the selected engine can pulse
	assign ready = wr_ready | rd_ready;
	assign rdata = rd_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy   <= 1'b0;
			sel_wr <= 1'b0;
			error  <= 1'b0;
		end else begin
			if (wr_status.done || rd_status.done) begin
				busy <= 1'b0;
			end else if (valid && !busy) begin
				busy   <= 1'b1;
				sel_wr <= (wstrb != '0);
			end
			// Error of the most recent burst
			if (wr_status.done)
				error <= wr_status.err;
			else if (rd_status.done)
				error <= rd_status.err;
		end
	end

	a_one_engine: assert property (@(posedge clk) disable iff (rst)
		!(wr_ready && rd_ready))
		else $error("Both engines pulsed ready");

	// A done pulse must come from the engine that owns the burst
	a_done_owner: assert property (@(posedge clk) disable iff (rst)
		(!wr_status.done || (busy && sel_wr)) && (!rd_status.done || (busy && !sel_wr)))
		else $error("Done from an engine that was not selected");

endmodule

// File: axi_dma/axi_dma_r.sv
`timescale 1ns/10ps

module axi_dma_r (
	input  logic                     clk,
	input  logic                     rst,

	// Databus side, already steered
	input  logic                     req_valid,
	input  axi_dma_pkg::addr_t       req_addr,
	input  axi_dma_pkg::dma_cfg_t    cfg,
	output logic                     beat_ready,
	output axi_dma_pkg::data_t       rdata,

	// AR channel
	output axi_dma_pkg::axi_addr_t   ar,
	output logic                     arvalid,
	input  logic                     arready,

	// R channel
	input  axi_dma_pkg::axi_r_t      r,
	input  logic                     rvalid,
	output logic                     rready,

	output axi_dma_pkg::eng_status_t status
);

	axi_dma_pkg::rd_state_t state, state_nxt;
	logic                   err_acc, err_acc_nxt;
	logic                   beat_err;

	assign ar = '{
		addr:  req_addr,
		len:   cfg.len,
		size:  cfg.size,
		burst: axi_dma_pkg::BURST_INCR,
		cache: axi_dma_pkg::CACHE_DEF,
		prot:  axi_dma_pkg::PROT_DEF
	};

	// Read data is valid whenever beat_ready pulses
	assign rdata    = r.data;
	assign beat_err = (r.resp != axi_dma_pkg::RESP_OKAY);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= axi_dma_pkg::R_ADDR;
			err_acc <= 1'b0;
		end else begin
			state   <= state_nxt;
			err_acc <= err_acc_nxt;
		end
	end

	always_comb begin
		state_nxt   = state;
		err_acc_nxt = err_acc;
		arvalid     = 1'b0;
		rready      = 1'b0;
		beat_ready  = 1'b0;
		status      = '0;
		case (state)
			axi_dma_pkg::R_ADDR: begin
				err_acc_nxt = 1'b0;
				arvalid     = req_valid;
				if (req_valid && arready)
					state_nxt = axi_dma_pkg::R_DATA;
			end
			axi_dma_pkg::R_DATA: begin
				rready     = req_valid;
				beat_ready = req_valid && rvalid;
				if (beat_ready) begin
					err_acc_nxt = err_acc | beat_err;
					// Slave marks the end of the burst
					if (r.last) begin
						status.done = 1'b1;
						status.err  = err_acc | beat_err;
						state_nxt   = axi_dma_pkg::R_ADDR;
					end
				end
			end
			default: state_nxt = axi_dma_pkg::R_ADDR;
		endcase
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

endmodule

// File: axi_dma/axi_dma_w.sv
`timescale 1ns/10ps

module axi_dma_w (
	input  logic                     clk,
	input  logic                     rst,

	// Databus side, already steered
	input  logic                     req_valid,
	input  axi_dma_pkg::addr_t       req_addr,
	input  axi_dma_pkg::data_t       req_wdata,
	input  axi_dma_pkg::strb_t       req_wstrb,
	input  axi_dma_pkg::dma_cfg_t    cfg,
	output logic                     beat_ready,

	// AW channel
	output axi_dma_pkg::axi_addr_t   aw,
	output logic                     awvalid,
	input  logic                     awready,

	// W channel
	output axi_dma_pkg::axi_w_t      w,
	output logic                     wvalid,
	input  logic                     wready,

	// B channel
	input  axi_dma_pkg::resp_t       bresp,
	input  logic                     bvalid,
	output logic                     bready,

	output axi_dma_pkg::eng_status_t status
);

	axi_dma_pkg::wr_state_t state, state_nxt;
	axi_dma_pkg::beat_cnt_t cnt, cnt_nxt;
	logic                   last_beat;

	// Address attributes follow the request and the configuration
	assign aw = '{
		addr:  req_addr,
		len:   cfg.len,
		size:  cfg.size,
		burst: axi_dma_pkg::BURST_INCR,
		cache: axi_dma_pkg::CACHE_DEF,
		prot:  axi_dma_pkg::PROT_DEF
	};

	assign last_beat = (state == axi_dma_pkg::W_DATA) && (cnt == {1'b0, cfg.len});

	// Write data goes straight from the databus
	assign w = '{
		data: req_wdata,
		strb: req_wstrb,
		last: last_beat
	};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= axi_dma_pkg::W_ADDR;
			cnt   <= '0;
		end else begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
		end
	end

	always_comb begin
		state_nxt  = state;
		cnt_nxt    = cnt;
		awvalid    = 1'b0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		beat_ready = 1'b0;
		status     = '0;
		case (state)
			axi_dma_pkg::W_ADDR: begin
				cnt_nxt = '0;
				awvalid = req_valid;
				if (req_valid && awready)
					state_nxt = axi_dma_pkg::W_DATA;
			end
			axi_dma_pkg::W_DATA: begin
				wvalid     = req_valid;
				beat_ready = req_valid && wready;
				if (beat_ready) begin
					cnt_nxt = cnt + 1'b1;
					if (last_beat)
						state_nxt = axi_dma_pkg::W_RESP;
				end
			end
			axi_dma_pkg::W_RESP: begin
				bready = 1'b1;
				if (bvalid) begin
					status.done = 1'b1;
					status.err  = (bresp != axi_dma_pkg::RESP_OKAY);
					state_nxt   = axi_dma_pkg::W_ADDR;
				end
			end
			default: state_nxt = axi_dma_pkg::W_ADDR;
		endcase
	end

	// Last only on a live beat
	a_wlast: assert property (@(posedge clk) disable iff (rst)
		w.last |-> wvalid)
		else $error("W last without wvalid");

	// User must keep the request up until AW is taken
	a_aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

endmodule

// File: common/axi_dma_pkg.sv
package axi_dma_pkg;

	// Bus and field widths
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int STRB_W  = DATA_W / 8;
	localparam int LEN_W   = 8;
	localparam int SIZE_W  = 3;
	localparam int RESP_W  = 2;
	localparam int BURST_W = 2;
	localparam int CACHE_W = 4;
	localparam int PROT_W  = 3;

	// Fixed AXI attributes
	localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
	localparam logic [CACHE_W-1:0] CACHE_DEF  = 4'h2;
	localparam logic [PROT_W-1:0]  PROT_DEF   = 3'b010;
	localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [LEN_W-1:0]  len_t;
	typedef logic [SIZE_W-1:0] size_t;
	typedef logic [RESP_W-1:0] resp_t;
	// One bit wider than len so a full count never wraps
	typedef logic [LEN_W:0]    beat_cnt_t;

	typedef struct packed {
		len_t  len;
		size_t size;
	} dma_cfg_t;

	// Shared by AW and AR
	typedef struct packed {
		addr_t              addr;
		len_t               len;
		size_t              size;
		logic [BURST_W-1:0] burst;
		logic [CACHE_W-1:0] cache;
		logic [PROT_W-1:0]  prot;
	} axi_addr_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
		logic  last;
	} axi_r_t;

	typedef struct packed {
		logic done;
		logic err;
	} eng_status_t;

	typedef enum logic [1:0] {W_ADDR, W_DATA, W_RESP} wr_state_t;
	typedef enum logic {R_ADDR, R_DATA} rd_state_t;

endpackage
